/* source/rv_pkg.sv */
package rv_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Widths and memory size
    ///////////////////////////////////////////////////////////////////////

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INS = 32'h0000_0013;

    ///////////////////////////////////////////////////////////////////////
    // Encodings
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // What execute has to do with a decoded slot
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_NONE
    } ins_class_e;

    // Arithmetic ops first, then the branch compares
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_op_e;

endpackage

/* source/ins_fetch.sv */
module ins_fetch (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           run_i,
    input  logic                           load_en_i,
    input  logic [rv_pkg::IMEM_ADDR_W-1:0] load_addr_i,
    input  logic [rv_pkg::XLEN-1:0]        load_data_i,
    input  logic                           redirect_i,
    input  logic [rv_pkg::XLEN-1:0]        redirect_pc_i,
    output logic [rv_pkg::XLEN-1:0]        ins_o,
    output logic [rv_pkg::XLEN-1:0]        ins_pc_o,
    output logic                           ins_valid_o
);
    import rv_pkg::*;

    logic [XLEN-1:0]        imem [IMEM_DEPTH];
    logic [XLEN-1:0]        pc;
    logic [IMEM_ADDR_W-1:0] pc_idx;

    // Word index wraps around the memory
    assign pc_idx = pc[IMEM_ADDR_W+1:2];

    ///////////////////////////////////////////////////////////////////////
    // Instruction memory, written only from the load port
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load_en_i) begin
            imem[load_addr_i] <= load_data_i;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // PC and fetch register
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc          <= '0;
            ins_o       <= NOP_INS;
            ins_valid_o <= 1'b0;
        end else if (redirect_i) begin
            // Drop the fall-through slot, restart at the target
            pc          <= redirect_pc_i;
            ins_o       <= NOP_INS;
            ins_valid_o <= 1'b0;
        end else if (run_i) begin
            ins_o       <= imem[pc_idx];
            ins_pc_o    <= pc;
            ins_valid_o <= 1'b1;
            pc          <= pc + 32'd4;
        end else begin
            ins_valid_o <= 1'b0;
        end
    end

endmodule

/* source/ins_decode.sv */
module ins_decode (
    input  logic [rv_pkg::XLEN-1:0]       ins_i,
    input  logic                          ins_valid_i,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [rv_pkg::XLEN-1:0]       imm_o,
    output rv_pkg::ins_class_e            ins_class_o,
    output rv_pkg::alu_op_e               alu_op_o
);
    import rv_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic [XLEN-1:0] imm_i_type;
    logic [XLEN-1:0] imm_u_type;
    logic [XLEN-1:0] imm_j_type;
    logic [XLEN-1:0] imm_b_type;
    logic [XLEN-1:0] imm_shamt;
    alu_op_e         arith_op;
    alu_op_e         branch_op;

    assign opcode    = opcode_e'(ins_i[6:0]);
    assign funct3    = ins_i[14:12];
    assign funct7_b5 = ins_i[30];

    // Sign-extended immediates, shift amount zero-extended
    assign imm_i_type = {{20{ins_i[31]}}, ins_i[31:20]};
    assign imm_u_type = {ins_i[31:12], 12'b0};
    assign imm_j_type = {{12{ins_i[31]}}, ins_i[19:12], ins_i[20], ins_i[30:21], 1'b0};
    assign imm_b_type = {{20{ins_i[31]}}, ins_i[7], ins_i[30:25], ins_i[11:8], 1'b0};
    assign imm_shamt  = {27'b0, ins_i[24:20]};

    // Shared by OP and OP-IMM, SUB exists only in register form
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  branch_op = ALU_BEQ;
            3'b001:  branch_op = ALU_BNE;
            3'b100:  branch_op = ALU_BLT;
            3'b101:  branch_op = ALU_BGE;
            3'b110:  branch_op = ALU_BLTU;
            default: branch_op = ALU_BGEU;
        endcase
    end

    always_comb begin
        rs1_o       = '0;
        rs2_o       = '0;
        rd_o        = '0;
        imm_o       = '0;
        ins_class_o = CLS_NONE;
        alu_op_o    = ALU_ADD;
        if (ins_valid_i) begin
            case (opcode)
                OPC_OP_IMM: begin
                    rs1_o       = ins_i[19:15];
                    rd_o        = ins_i[11:7];
                    ins_class_o = CLS_ALU;
                    alu_op_o    = arith_op;
                    imm_o       = (funct3[1:0] == 2'b01) ? imm_shamt : imm_i_type;
                end
                OPC_OP: begin
                    rs1_o       = ins_i[19:15];
                    rs2_o       = ins_i[24:20];
                    rd_o        = ins_i[11:7];
                    ins_class_o = CLS_ALU;
                    alu_op_o    = arith_op;
                end
                OPC_LUI, OPC_AUIPC: begin
                    rd_o        = ins_i[11:7];
                    imm_o       = imm_u_type;
                    ins_class_o = (opcode == OPC_LUI) ? CLS_LUI : CLS_AUIPC;
                end
                OPC_JAL: begin
                    rd_o        = ins_i[11:7];
                    imm_o       = imm_j_type;
                    ins_class_o = CLS_JAL;
                end
                OPC_JALR: begin
                    rs1_o       = ins_i[19:15];
                    rd_o        = ins_i[11:7];
                    imm_o       = imm_i_type;
                    ins_class_o = CLS_JALR;
                end
                OPC_BRANCH: begin
                    // funct3 010 and 011 are not branches
                    if (funct3[2:1] != 2'b01) begin
                        rs1_o       = ins_i[19:15];
                        rs2_o       = ins_i[24:20];
                        imm_o       = imm_b_type;
                        ins_class_o = CLS_BRANCH;
                        alu_op_o    = branch_op;
                    end
                end
                default: begin
                    ins_class_o = CLS_NONE;
                end
            endcase
        end
    end

endmodule

/* source/reg_file.sv */
module reg_file (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                          wr_en_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [rv_pkg::XLEN-1:0]       wr_data_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o
);
    import rv_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* source/alu_exec.sv */
module alu_exec (
    input  logic                          ins_valid_i,
    input  logic [rv_pkg::XLEN-1:0]       ins_pc_i,
    input  rv_pkg::ins_class_e            ins_class_i,
    input  rv_pkg::alu_op_e               alu_op_i,
    input  logic [rv_pkg::XLEN-1:0]       imm_i,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
    output logic                          wr_en_o,
    output logic [rv_pkg::XLEN-1:0]       wr_data_o,
    output logic                          redirect_o,
    output logic [rv_pkg::XLEN-1:0]       redirect_pc_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            taken;
    logic            writes_rd;

    // Decode zeroes the unused source, so rs2 or the immediate passes alone
    assign op_b = rs2_data_i | imm_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_res = rs1_data_i + op_b;
            ALU_SUB:  alu_res = rs1_data_i - op_b;
            ALU_SLL:  alu_res = rs1_data_i << op_b[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, rs1_data_i < op_b};
            ALU_XOR:  alu_res = rs1_data_i ^ op_b;
            ALU_SRL:  alu_res = rs1_data_i >> op_b[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(rs1_data_i) >>> op_b[4:0]);
            ALU_OR:   alu_res = rs1_data_i | op_b;
            ALU_AND:  alu_res = rs1_data_i & op_b;
            default:  alu_res = '0;
        endcase
    end

    // Branch condition on the raw register values
    always_comb begin
        case (alu_op_i)
            ALU_BEQ:  taken = (rs1_data_i == rs2_data_i);
            ALU_BNE:  taken = (rs1_data_i != rs2_data_i);
            ALU_BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            ALU_BGE:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            ALU_BLTU: taken = (rs1_data_i < rs2_data_i);
            ALU_BGEU: taken = (rs1_data_i >= rs2_data_i);
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        case (ins_class_i)
            CLS_ALU:           wr_data_o = alu_res;
            CLS_LUI:           wr_data_o = imm_i;
            CLS_AUIPC:         wr_data_o = ins_pc_i + imm_i;
            CLS_JAL, CLS_JALR: wr_data_o = ins_pc_i + 32'd4;
            default:           wr_data_o = '0;
        endcase
    end

    assign writes_rd = ins_class_i inside {CLS_ALU, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR};
    assign wr_en_o   = ins_valid_i && writes_rd && rd_i != '0;

    assign redirect_o = ins_valid_i && (ins_class_i == CLS_JAL || ins_class_i == CLS_JALR
                                        || (ins_class_i == CLS_BRANCH && taken));

    // JALR target is register based with bit 0 cleared
    assign redirect_pc_o = (ins_class_i == CLS_JALR) ? ((rs1_data_i + imm_i) & ~32'd1)
                                                     : (ins_pc_i + imm_i);

endmodule

/* source/retire_stage.sv */
module retire_stage (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          ins_valid_i,
    input  logic [rv_pkg::XLEN-1:0]       ins_pc_i,
    input  logic                          wr_en_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [rv_pkg::XLEN-1:0]       wr_data_i,
    output logic                          retire_valid_o,
    output logic [rv_pkg::XLEN-1:0]       retire_pc_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [rv_pkg::XLEN-1:0]       retire_data_o,
    output logic [rv_pkg::XLEN-1:0]       retire_count_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
            retire_count_o <= '0;
        end else begin
            retire_valid_o <= ins_valid_i;
            if (ins_valid_i) begin
                retire_count_o <= retire_count_o + 32'd1;
            end
        end
    end

    // Report x0 and zero when nothing was written
    always_ff @(posedge clk) begin
        if (ins_valid_i) begin
            retire_pc_o   <= ins_pc_i;
            retire_rd_o   <= wr_en_i ? wr_addr_i : '0;
            retire_data_o <= wr_en_i ? wr_data_i : '0;
        end
    end

endmodule

/* source/rv_core_top.sv */
module rv_core_top (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           run_i,
    input  logic                           load_en_i,
    input  logic [rv_pkg::IMEM_ADDR_W-1:0] load_addr_i,
    input  logic [rv_pkg::XLEN-1:0]        load_data_i,
    output logic                           retire_valid_o,
    output logic [rv_pkg::XLEN-1:0]        retire_pc_o,
    output logic [rv_pkg::REG_ADDR_W-1:0]  retire_rd_o,
    output logic [rv_pkg::XLEN-1:0]        retire_data_o,
    output logic [rv_pkg::XLEN-1:0]        retire_count_o
);
    import rv_pkg::*;

    ///////////////////////////////////////////////////////////////////////
    // Stage to stage wires
    ///////////////////////////////////////////////////////////////////////

    logic [XLEN-1:0]       ins;
    logic [XLEN-1:0]       ins_pc;
    logic                  ins_valid;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    ins_class_e            ins_class;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  wr_en;
    logic [XLEN-1:0]       wr_data;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;

    ///////////////////////////////////////////////////////////////////////
    // Fetch, decode, execute, retire
    ///////////////////////////////////////////////////////////////////////

    ins_fetch u_fetch (
        .clk           (clk),
        .rst_i         (rst_i),
        .run_i         (run_i),
        .load_en_i     (load_en_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .ins_o         (ins),
        .ins_pc_o      (ins_pc),
        .ins_valid_o   (ins_valid)
    );

    ins_decode u_decode (
        .ins_i       (ins),
        .ins_valid_i (ins_valid),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .imm_o       (imm),
        .ins_class_o (ins_class),
        .alu_op_o    (alu_op)
    );

    reg_file u_regs (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wr_en_i    (wr_en),
        .wr_addr_i  (rd),
        .wr_data_i  (wr_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    alu_exec u_exec (
        .ins_valid_i   (ins_valid),
        .ins_pc_i      (ins_pc),
        .ins_class_i   (ins_class),
        .alu_op_i      (alu_op),
        .imm_i         (imm),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rd_i          (rd),
        .wr_en_o       (wr_en),
        .wr_data_o     (wr_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    retire_stage u_retire (
        .clk            (clk),
        .rst_i          (rst_i),
        .ins_valid_i    (ins_valid),
        .ins_pc_i       (ins_pc),
        .wr_en_i        (wr_en),
        .wr_addr_i      (rd),
        .wr_data_i      (wr_data),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .retire_count_o (retire_count_o)
    );

endmodule

/* tb/tb_clock.sv */
module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

endmodule

/* tb/rv_core_chk.sv */
module rv_core_chk (
    input logic                          clk,
    input logic                          rst_i,
    input logic                          run_i,
    input logic                          ins_valid_i,
    input logic                          wr_en_i,
    input logic                          retire_valid_i,
    input logic [rv_pkg::REG_ADDR_W-1:0] retire_rd_i,
    input logic [rv_pkg::XLEN-1:0]       retire_data_i,
    input logic [rv_pkg::XLEN-1:0]       retire_count_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // No retire report while reset is held
    assert property (@(posedge clk) rst_i |=> !retire_valid_i)
        else begin $error("retire_valid_o high during reset"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_i |-> retire_count_i == $past(retire_count_i) + 32'd1)
        else begin $error("retire counter did not step by one"); fail_count++; end

    // Slot without a write reports x0 and zero
    assert property (@(posedge clk) disable iff (rst_i)
        ins_valid_i && !wr_en_i |=> retire_rd_i == '0 && retire_data_i == '0)
        else begin $error("retire without write reports a register"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst_i)
        !run_i && $past(!run_i) |=> !retire_valid_i)
        else begin $error("retire while fetch is stopped"); fail_count++; end

endmodule

bind rv_core_top rv_core_chk u_chk (
    .clk            (clk),
    .rst_i          (rst_i),
    .run_i          (run_i),
    .ins_valid_i    (ins_valid),
    .wr_en_i        (wr_en),
    .retire_valid_i (retire_valid_o),
    .retire_rd_i    (retire_rd_o),
    .retire_data_i  (retire_data_o),
    .retire_count_i (retire_count_o)
);

/* tb/rv_core_tb.sv */
module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int PROG_WORDS     = 32;
    localparam int RUN_RETIRES    = 48;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (PROG_WORDS + 5 + 2 * RUN_RETIRES + 20);

    logic                   clk;
    logic                   rst_i;
    logic                   run_i;
    logic                   load_en_i;
    logic [IMEM_ADDR_W-1:0] load_addr_i;
    logic [XLEN-1:0]        load_data_i;
    logic                   retire_valid_o;
    logic [XLEN-1:0]        retire_pc_o;
    logic [REG_ADDR_W-1:0]  retire_rd_o;
    logic [XLEN-1:0]        retire_data_o;
    logic [XLEN-1:0]        retire_count_o;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic [31:0] rng_state = 32'h671915e7;
    int          seen;
    int          err_count = 0;
    int          cycle_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    string       test_name;
    string       names [NUM_TESTS] = '{"alu_ops", "upper_imm", "branches", "jumps",
                                       "x0_unsupported", "reset_counter"};

    tb_clock u_clock (.clk_o(clk));

    rv_core_top uut (
        .clk            (clk),
        .rst_i          (rst_i),
        .run_i          (run_i),
        .load_en_i      (load_en_i),
        .load_addr_i    (load_addr_i),
        .load_data_i    (load_data_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .retire_count_o (retire_count_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Program generator
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] gen_ins(input int mode, input int idx);
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [20:0] off;
        int          kind;
        int          cls;
        int          tgt;
        r    = next_rand();
        r2   = next_rand();
        f3   = r[2:0];
        rd   = (mode == 5) ? {3'b0, r[4:3]} : {2'b0, r[5:3]};
        rs1  = {2'b0, r[8:6]};
        rs2  = {2'b0, r[11:9]};
        tgt  = int'(r2[16:12]);
        kind = int'(r2[23:20]) % 10;
        // Last word jumps back so fetch stays inside the program
        if (idx == PROG_WORDS - 1) begin
            off = 21'((tgt % 31 - idx) * 4);
            return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
        end
        // Load word is unsupported by the core
        if (mode == 5 && idx % 8 == 3) begin
            return {r[31:20], rs1, 3'b010, rd | 5'd1, 7'b0000011};
        end
        case (mode)
            1:       cls = (kind < 5) ? 0 : 1;
            2:       cls = (kind < 5) ? 2 : ((kind < 8) ? 0 : 1);
            3:       cls = (kind < 4) ? 3 : ((kind < 8) ? 0 : 1);
            4:       cls = (kind < 3) ? 4 : ((kind < 7) ? 0 : 1);
            5:       cls = (kind < 6) ? 0 : 1;
            default: cls = kind % 5;
        endcase
        case (cls)
            0: begin
                imm12 = r[31:20];
                if (f3 == 3'd1) imm12 = {7'b0, r[24:20]};
                if (f3 == 3'd5) imm12 = {1'b0, r2[25], 5'b0, r[24:20]};
                return {imm12, rs1, f3, rd, OPC_OP_IMM};
            end
            1: begin
                return {1'b0, r2[25] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd,
                        OPC_OP};
            end
            2: return {r[31:12], rd, r2[24] ? OPC_LUI : OPC_AUIPC};
            3: begin
                f3 = r2[2:0];
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                off = 21'((tgt - idx) * 4);
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
            end
            default: begin
                if (r2[3]) begin
                    off = 21'((tgt - idx) * 4);
                    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
                end
                // Odd offset now and then so the target drops bit 0
                imm12 = 12'(tgt * 4) | {11'b0, r2[4]};
                return {imm12, 5'd0, 3'b000, rd, OPC_JALR};
            end
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference ISA model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                // Sign fill for the arithmetic form
                if (alt && a[31]) begin
                    return (a >> b[4:0]) | ~(32'hffff_ffff >> b[4:0]);
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes the instruction at ref_pc and returns what the core must report
    function automatic void model_step(output logic [XLEN-1:0] exp_pc,
                                       output logic [REG_ADDR_W-1:0] exp_rd,
                                       output logic [XLEN-1:0] exp_data);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] nxt;
        logic [2:0]  f3;
        logic        wr;
        logic        taken;
        ins   = prog[ref_pc[6:2]];
        f3    = ins[14:12];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        res   = '0;
        wr    = 1'b1;
        taken = 1'b0;
        nxt   = ref_pc + 32'd4;
        case (ins[6:0])
            OPC_OP_IMM: res = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
            OPC_OP:     res = alu_ref(f3, ins[30], a, b);
            OPC_LUI:    res = {ins[31:12], 12'b0};
            OPC_AUIPC:  res = ref_pc + {ins[31:12], 12'b0};
            OPC_JAL: begin
                res = ref_pc + 32'd4;
                nxt = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                res = ref_pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    nxt = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: wr = 1'b0;
        endcase
        if (ins[11:7] == 5'd0) wr = 1'b0;
        exp_pc   = ref_pc;
        exp_rd   = wr ? ins[11:7] : '0;
        exp_data = wr ? res : '0;
        if (wr) ref_regs[ins[11:7]] = res;
        ref_pc = nxt;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks and comparison
    //////////////////////////////////////////////////////////////////////

    task automatic check_pc(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s pc expected %h actual %h", test_name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_rd(input logic [REG_ADDR_W-1:0] exp,
                            input logic [REG_ADDR_W-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s rd expected %0d actual %0d", test_name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_data(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s data expected %h actual %h", test_name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_count(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s count expected %0d actual %0d", test_name, exp, act);
            err_count++;
        end
    endtask

    always @(posedge clk) begin : compare_retire
        logic [XLEN-1:0]       exp_pc;
        logic [REG_ADDR_W-1:0] exp_rd;
        logic [XLEN-1:0]       exp_data;
        if (rst_i) begin
            ref_pc = '0;
            for (int i = 0; i < 32; i++) begin
                ref_regs[i] = '0;
            end
            seen <= 0;
        end else if (retire_valid_o) begin
            model_step(exp_pc, exp_rd, exp_data);
            check_pc(exp_pc, retire_pc_o);
            check_rd(exp_rd, retire_rd_o);
            check_data(exp_data, retire_data_o);
            check_count(seen + 1, retire_count_o);
            seen <= seen + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    task automatic reset_dut();
        @(posedge clk);
        rst_i <= 1'b1;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge clk);
            load_en_i   <= 1'b1;
            load_addr_i <= i[IMEM_ADDR_W-1:0];
            load_data_i <= prog[i];
        end
        @(posedge clk);
        load_en_i <= 1'b0;
    endtask

    task automatic run_test(input int num);
        int errs_before;
        int asrt_before;
        int idle;
        int asrt;
        test_name   = names[num - 1];
        errs_before = err_count;
        asrt_before = int'(uut.u_chk.fail_count);
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = gen_ins(num, i);
        end
        reset_dut();
        load_program();
        run_i <= 1'b1;
        do @(posedge clk); while (seen < RUN_RETIRES);
        run_i <= 1'b0;
        // Instructions in flight still retire
        idle = 0;
        while (idle < 2) begin
            @(posedge clk);
            idle = retire_valid_o ? 0 : idle + 1;
        end
        asrt = int'(uut.u_chk.fail_count) - asrt_before;
        if (err_count == errs_before && asrt == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d retires, %0d mismatches, %0d assertion failures",
                 num, test_name, (err_count == errs_before && asrt == 0) ? "ok" : "FAILED",
                 seen, err_count - errs_before, asrt);
    endtask

    initial begin
        rst_i       <= 1'b1;
        run_i       <= 1'b0;
        load_en_i   <= 1'b0;
        load_addr_i <= '0;
        load_data_i <= '0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0 && uut.u_chk.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sources.f */
source/rv_pkg.sv
source/ins_fetch.sv
source/ins_decode.sv
source/reg_file.sv
source/alu_exec.sv
source/retire_stage.sv
source/rv_core_top.sv
tb/tb_clock.sv
tb/rv_core_chk.sv
tb/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rv_core_tb -f sources.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
